/* Makefile */
# Verilator build and run for the video controller testbench.

VERILATOR ?= verilator
TOP ?= tb_video_controller
FILELIST ?= video_controller.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/100ps -j 0
PASS_TEXT ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST)) video_config.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu_bus_decoder.sv */
`include "video_config.svh"

module cpu_bus_decoder (
	input logic i_clock,
	input logic i_rst,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::word_t i_cpu_wdata,
	output video_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::addr_t o_vram_pa_address,
	output video_pkg::word_t o_vram_pa_wdata,
	input video_pkg::word_t i_vram_pa_rdata,
	input logic i_vram_pa_ready,

	output logic o_pal_we,
	output video_pkg::pal_index_t o_pal_index,
	output video_pkg::rgb_t o_pal_data,

	output video_pkg::addr_t o_frame_base,
	input logic i_fetch_busy
);

	// Set from acceptance until the ready pulse has gone out.
	logic busy;

	video_pkg::addr_t pal_offset;
	video_pkg::addr_t ctrl_word;

	assign pal_offset = i_cpu_address - `VRAM_LIMIT;
	assign ctrl_word = (i_cpu_address - `PALETTE_LIMIT) >> 2;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			busy <= 1'b0;
			o_cpu_ready <= 1'b0;
			o_vram_pa_request <= 1'b0;
			o_pal_we <= 1'b0;
			o_frame_base <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			o_pal_we <= 1'b0;

			if (o_cpu_ready) begin
				// The CPU drops its request now.
				busy <= 1'b0;
			end else if (o_vram_pa_request) begin
				// Hold port A until the memory answers.
				if (i_vram_pa_ready) begin
					o_vram_pa_request <= 1'b0;
					o_cpu_rdata <= i_vram_pa_rdata;
					o_cpu_ready <= 1'b1;
				end
			end else if (!busy && i_cpu_request) begin
				busy <= 1'b1;
				if (i_cpu_address < `VRAM_LIMIT) begin
					o_vram_pa_request <= 1'b1;
					o_vram_pa_rw <= i_cpu_rw;
					o_vram_pa_address <= i_cpu_address;
					o_vram_pa_wdata <= i_cpu_wdata;
				end else if (i_cpu_address < `PALETTE_LIMIT) begin
					// Write only, a read returns zero.
					o_pal_we <= i_cpu_rw;
					o_pal_index <= pal_offset[9:2];
					o_pal_data <= i_cpu_wdata[23:0];
					o_cpu_rdata <= '0;
					o_cpu_ready <= 1'b1;
				end else begin
					o_cpu_rdata <= '0;
					if (ctrl_word == `CTRL_BASE_OFFSET) begin
						if (i_cpu_rw)
							o_frame_base <= i_cpu_wdata;
						o_cpu_rdata <= o_frame_base;
					end else if (ctrl_word == `CTRL_STATUS_OFFSET) begin
						o_cpu_rdata <= {31'd0, i_fetch_busy};
					end
					o_cpu_ready <= 1'b1;
				end
			end
		end
	end

endmodule

/* line_fetcher.sv */
`include "video_config.svh"

module line_fetcher (
	input logic i_clock,
	input logic i_rst,

	input logic i_hblank,
	input logic i_vblank,

	input video_pkg::addr_t i_frame_base,

	output logic o_vram_pb_request,
	output video_pkg::addr_t o_vram_pb_address,
	input video_pkg::word_t i_vram_pb_rdata,
	input logic i_vram_pb_ready,

	output logic o_line_we,
	output video_pkg::line_index_t o_line_index,
	output video_pkg::word_t o_line_data,

	output logic o_fetch_busy
);

	video_pkg::fetch_state_t state;

	logic hblank_q;
	logic vblank_q;
	logic pend_v;
	logic pend_h;
	logic v_event;
	logic h_event;

	// Set on every other visible line, the row advances when it sets.
	logic doubled;

	video_pkg::addr_t row_addr;
	video_pkg::line_index_t word_idx;

	// Hblank only counts inside the visible region.
	assign v_event = pend_v | (i_vblank & ~vblank_q);
	assign h_event = pend_h | (i_hblank & ~hblank_q & ~i_vblank);

	assign o_fetch_busy = (state != video_pkg::FETCH_IDLE);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= video_pkg::FETCH_IDLE;
			hblank_q <= 1'b0;
			vblank_q <= 1'b0;
			pend_v <= 1'b0;
			pend_h <= 1'b0;
			doubled <= 1'b0;
			row_addr <= '0;
			o_vram_pb_request <= 1'b0;
			o_line_we <= 1'b0;
		end else begin
			hblank_q <= i_hblank;
			vblank_q <= i_vblank;
			o_line_we <= 1'b0;

			// Edges seen during a fetch wait here.
			pend_v <= v_event;
			pend_h <= h_event;

			case (state)
				video_pkg::FETCH_IDLE: begin
					if (v_event) begin
						pend_v <= 1'b0;
						pend_h <= 1'b0;
						doubled <= 1'b0;
						row_addr <= i_frame_base;
						o_vram_pb_address <= i_frame_base;
						word_idx <= '0;
						state <= video_pkg::FETCH_REQUEST;
					end else if (h_event) begin
						pend_h <= 1'b0;
						doubled <= ~doubled;
						if (!doubled) begin
							row_addr <= row_addr + 32'(`VIDEO_PITCH);
							o_vram_pb_address <= row_addr + 32'(`VIDEO_PITCH);
							word_idx <= '0;
							state <= video_pkg::FETCH_REQUEST;
						end
					end
				end

				video_pkg::FETCH_REQUEST: begin
					o_vram_pb_request <= 1'b1;
					state <= video_pkg::FETCH_WAIT_READY;
				end

				video_pkg::FETCH_WAIT_READY: begin
					if (i_vram_pb_ready) begin
						o_vram_pb_request <= 1'b0;
						o_line_we <= 1'b1;
						o_line_index <= word_idx;
						o_line_data <= i_vram_pb_rdata;
						if (word_idx == video_pkg::line_index_t'(`VIDEO_LINE_WORDS - 1)) begin
							state <= video_pkg::FETCH_IDLE;
						end else begin
							word_idx <= word_idx + 7'd1;
							o_vram_pb_address <= o_vram_pb_address + 32'd4;
							state <= video_pkg::FETCH_GAP;
						end
					end
				end

				// Memory must drop ready before the next word.
				video_pkg::FETCH_GAP: begin
					if (!i_vram_pb_ready)
						state <= video_pkg::FETCH_REQUEST;
				end

				default: begin
					state <= video_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

endmodule

/* pixel_lookup.sv */
`include "video_config.svh"

module pixel_lookup (
	input logic i_clock,
	input logic i_rst,

	input logic i_line_we,
	input video_pkg::line_index_t i_line_index,
	input video_pkg::word_t i_line_data,

	input logic i_pal_we,
	input video_pkg::pal_index_t i_pal_index,
	input video_pkg::rgb_t i_pal_data,

	input video_pkg::pos_t i_pos_x,

	output video_pkg::rgb_t o_pixel_rgb
);

	// ==================================================================
	// Storage
	// ==================================================================

	video_pkg::word_t line_buf [0:`VIDEO_LINE_WORDS-1];
	video_pkg::rgb_t palette [0:255];

	video_pkg::line_index_t rd_index;
	video_pkg::word_t rd_word;
	video_pkg::pal_index_t pixel_index;

	always_ff @(posedge i_clock) begin
		if (i_line_we)
			line_buf[i_line_index] <= i_line_data;
	end

	always_ff @(posedge i_clock) begin
		if (i_pal_we)
			palette[i_pal_index] <= i_pal_data;
	end

	// ==================================================================
	// Pixel path
	// ==================================================================

	// Four pixels per word, lowest byte first.
	assign rd_index = i_pos_x[8:2];
	assign rd_word = line_buf[rd_index];

	always_comb begin
		case (i_pos_x[1:0])
			2'd0: pixel_index = rd_word[7:0];
			2'd1: pixel_index = rd_word[15:8];
			2'd2: pixel_index = rd_word[23:16];
			default: pixel_index = rd_word[31:24];
		endcase
	end

	// Colour shows one cycle after x.
	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_pixel_rgb <= '0;
		else
			o_pixel_rgb <= palette[pixel_index];
	end

endmodule

/* tb_video_controller.sv */
`include "video_config.svh"

module tb_video_controller;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CPU_TIMEOUT = 200;
	localparam int POLL_LIMIT = 400;
	localparam int VRAM_WORDS = 4096;
	localparam video_pkg::addr_t BASE_REG = `PALETTE_LIMIT + (`CTRL_BASE_OFFSET << 2);
	localparam video_pkg::addr_t STATUS_REG = `PALETTE_LIMIT + (`CTRL_STATUS_OFFSET << 2);

	typedef enum {
		OP_WRITE, OP_READ, OP_MEMCHK, OP_PALETTE, OP_VBLANK,
		OP_HBLANK, OP_SWEEP, OP_STALL, OP_COUNT
	} op_kind_t;

	typedef struct {
		string name;
		op_kind_t kind;
		video_pkg::addr_t address;
		video_pkg::word_t data;
		video_pkg::word_t expected;
	} op_t;

	logic clock;
	logic rst;
	logic cpu_request;
	logic cpu_rw;
	video_pkg::addr_t cpu_address;
	video_pkg::word_t cpu_wdata;
	video_pkg::word_t cpu_rdata;
	logic cpu_ready;
	logic pa_request;
	logic pa_rw;
	video_pkg::addr_t pa_address;
	video_pkg::word_t pa_wdata;
	video_pkg::word_t pa_rdata = '0;
	logic pa_ready = 1'b0;
	logic pb_request;
	video_pkg::addr_t pb_address;
	video_pkg::word_t pb_rdata = '0;
	logic pb_ready = 1'b0;
	logic hblank;
	logic vblank;
	video_pkg::pos_t pos_x;
	video_pkg::rgb_t pixel_rgb;

	// ======================================================================
	// VRAM model
	// ======================================================================

	video_pkg::word_t vram [0:VRAM_WORDS-1];
	logic [31:0] lcg_state = 32'h9e4b;
	logic long_stalls = 1'b0;
	int pa_wait = 0;
	int pb_wait = 0;
	int pa_accesses = 0;
	int pa_mark = 0;
	op_t ops[$];

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int next_delay();
		logic [31:0] r;
		r = lcg_next();
		if (long_stalls)
			return 8 + int'(r[23:16] % 8'd17);
		return 1 + int'(r[23:16] % 8'd3);
	endfunction

	function automatic int word_index(input video_pkg::addr_t address);
		return int'(address[13:2]);
	endfunction

	function automatic video_pkg::rgb_t palette_color(input video_pkg::pal_index_t index);
		return {index, index ^ 8'ha5, ~index};
	endfunction

	// One process answers both ports from a shared delay sequence.
	always @(negedge clock) begin
		if (pa_ready) begin
			pa_ready = 1'b0;
		end else if (pa_request) begin
			if (pa_wait == 0)
				pa_wait = next_delay();
			pa_wait = pa_wait - 1;
			if (pa_wait == 0) begin
				if (pa_rw)
					vram[word_index(pa_address)] = pa_wdata;
				else
					pa_rdata = vram[word_index(pa_address)];
				pa_accesses++;
				pa_ready = 1'b1;
			end
		end
		if (pb_ready) begin
			pb_ready = 1'b0;
		end else if (pb_request) begin
			if (pb_wait == 0)
				pb_wait = next_delay();
			pb_wait = pb_wait - 1;
			if (pb_wait == 0) begin
				pb_rdata = vram[word_index(pb_address)];
				pb_ready = 1'b1;
			end
		end
	end

	video_controller dut (
		.i_clock(clock),
		.i_rst(rst),
		.i_cpu_request(cpu_request),
		.i_cpu_rw(cpu_rw),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.o_cpu_rdata(cpu_rdata),
		.o_cpu_ready(cpu_ready),
		.o_vram_pa_request(pa_request),
		.o_vram_pa_rw(pa_rw),
		.o_vram_pa_address(pa_address),
		.o_vram_pa_wdata(pa_wdata),
		.i_vram_pa_rdata(pa_rdata),
		.i_vram_pa_ready(pa_ready),
		.o_vram_pb_request(pb_request),
		.o_vram_pb_address(pb_address),
		.i_vram_pb_rdata(pb_rdata),
		.i_vram_pb_ready(pb_ready),
		.i_hblank(hblank),
		.i_vblank(vblank),
		.i_pos_x(pos_x),
		.o_pixel_rgb(pixel_rgb)
	);

	video_checker u_checker (
		.i_clock(clock),
		.i_cpu_ready(cpu_ready),
		.i_cpu_rdata(cpu_rdata),
		.i_pixel_rgb(pixel_rgb)
	);

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic add_op(input string name, input op_kind_t kind, input video_pkg::addr_t address,
			input video_pkg::word_t data, input video_pkg::word_t expected);
		op_t op;
		op.name = name;
		op.kind = kind;
		op.address = address;
		op.data = data;
		op.expected = expected;
		ops.push_back(op);
	endtask

	task automatic build_table();
		add_op("vram_write", OP_WRITE, 32'h0000_0100, 32'hcafe_1234, '0);
		add_op("vram_read", OP_READ, 32'h0000_0100, '0, 32'hcafe_1234);
		add_op("vram_model", OP_MEMCHK, 32'h0000_0100, '0, 32'hcafe_1234);
		add_op("base_write", OP_WRITE, BASE_REG, 32'h0000_1400, '0);
		add_op("base_read", OP_READ, BASE_REG, '0, 32'h0000_1400);
		add_op("base_clear", OP_WRITE, BASE_REG, '0, '0);
		add_op("base_zero", OP_READ, BASE_REG, '0, '0);
		add_op("palette_load", OP_PALETTE, '0, '0, '0);
		// Blanking entries expect status bit 0 on the first poll.
		add_op("vblank_0", OP_VBLANK, '0, '0, 32'd1);
		add_op("status_idle", OP_READ, STATUS_REG, '0, '0);
		add_op("row0", OP_SWEEP, 32'd0, '0, '0);
		// First edge after vblank sets the doubling flag and fetches row 1.
		add_op("hblank_1", OP_HBLANK, '0, '0, 32'd1);
		add_op("row1_first", OP_SWEEP, 32'd320, '0, '0);
		// Second edge only clears the flag.
		add_op("hblank_2", OP_HBLANK, '0, '0, 32'd0);
		add_op("row1_again", OP_SWEEP, 32'd320, '0, '0);
		add_op("hblank_3", OP_HBLANK, '0, '0, 32'd1);
		add_op("row2", OP_SWEEP, 32'd640, '0, '0);
		add_op("base_moved", OP_WRITE, BASE_REG, 32'h0000_1400, '0);
		add_op("vblank_1", OP_VBLANK, '0, '0, 32'd1);
		add_op("row0_moved", OP_SWEEP, 32'h0000_1400, '0, '0);
		add_op("long_stalls", OP_STALL, '0, '0, '0);
		add_op("stall_write_a", OP_WRITE, 32'h0000_0200, 32'h1357_9bdf, '0);
		add_op("stall_write_b", OP_WRITE, 32'h0000_0204, 32'h2468_ace0, '0);
		add_op("stall_read_a", OP_READ, 32'h0000_0200, '0, 32'h1357_9bdf);
		add_op("stall_write_c", OP_WRITE, 32'h0000_0200, 32'h0f1e_2d3c, '0);
		add_op("stall_read_c", OP_READ, 32'h0000_0200, '0, 32'h0f1e_2d3c);
		add_op("stall_read_b", OP_READ, 32'h0000_0204, '0, 32'h2468_ace0);
		add_op("stall_model_a", OP_MEMCHK, 32'h0000_0200, '0, 32'h0f1e_2d3c);
		add_op("stall_model_b", OP_MEMCHK, 32'h0000_0204, '0, 32'h2468_ace0);
		add_op("stall_accesses", OP_COUNT, '0, '0, 32'd6);
	endtask

	// Holds the request until ready, then drops it and idles one cycle.
	task automatic cpu_access(input logic rw, input video_pkg::addr_t address,
			input video_pkg::word_t wdata, output video_pkg::word_t rdata, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		rdata = '0;
		cpu_request = 1'b1;
		cpu_rw = rw;
		cpu_address = address;
		cpu_wdata = wdata;
		while (!ok && cycles < CPU_TIMEOUT) begin
			@(negedge clock);
			cycles++;
			if (cpu_ready) begin
				ok = 1'b1;
				rdata = cpu_rdata;
			end
		end
		cpu_request = 1'b0;
		if (!ok)
			u_checker.note_failure($sformatf("CPU access to %h got no ready", address));
		@(negedge clock);
	endtask

	task automatic wait_fetch_done(input string name, input logic expect_busy);
		video_pkg::word_t status;
		logic ok;
		logic done;
		int polls;
		done = 1'b0;
		polls = 0;
		while (!done && polls < POLL_LIMIT) begin
			cpu_access(1'b0, STATUS_REG, '0, status, ok);
			// The first poll lands well inside any fetch the edge started.
			if (ok && polls == 0)
				u_checker.check_value($sformatf("%s busy", name),
					{31'd0, expect_busy}, status);
			polls++;
			if (ok && status[0] == 1'b0)
				done = 1'b1;
		end
		if (!done)
			u_checker.note_failure($sformatf("%s: line fetch never finished", name));
	endtask

	task automatic sweep_row(input string name, input video_pkg::addr_t row_address);
		video_pkg::word_t row_word;
		video_pkg::pal_index_t index;
		int x;
		for (x = 0; x < `VIDEO_PITCH; x++) begin
			// Pixel x is byte x mod 4 of word x / 4 from the low end.
			row_word = vram[word_index(row_address + 32'((x / 4) * 4))];
			index = row_word[8 * (x % 4) +: 8];
			pos_x = video_pkg::pos_t'(x);
			u_checker.expect_pixel($sformatf("%s x=%0d", name, x), palette_color(index));
			@(negedge clock);
		end
		u_checker.stop_pixel();
		@(negedge clock);
	endtask

	task automatic run_op(input op_t op);
		video_pkg::word_t rdata;
		logic ok;
		int i;
		case (op.kind)
			OP_WRITE: cpu_access(1'b1, op.address, op.data, rdata, ok);
			OP_READ: begin
				u_checker.expect_read(op.name, op.expected);
				cpu_access(1'b0, op.address, '0, rdata, ok);
			end
			OP_MEMCHK: u_checker.check_value(op.name, op.expected, vram[word_index(op.address)]);
			OP_PALETTE: begin
				// Upper byte is junk and must be ignored.
				for (i = 0; i < 256; i++)
					cpu_access(1'b1, `VRAM_LIMIT + 32'(i * 4),
						{8'h5c, palette_color(8'(i))}, rdata, ok);
			end
			OP_VBLANK: begin
				vblank = 1'b1;
				repeat (2) @(negedge clock);
				wait_fetch_done(op.name, op.expected[0]);
				vblank = 1'b0;
				@(negedge clock);
			end
			OP_HBLANK: begin
				hblank = 1'b1;
				repeat (2) @(negedge clock);
				hblank = 1'b0;
				wait_fetch_done(op.name, op.expected[0]);
			end
			OP_SWEEP: sweep_row(op.name, op.address);
			OP_STALL: begin
				long_stalls = 1'b1;
				pa_mark = pa_accesses;
			end
			OP_COUNT: u_checker.check_value(op.name, op.expected, 32'(pa_accesses - pa_mark));
			default: u_checker.note_failure($sformatf("%s: unknown table entry", op.name));
		endcase
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		int i;
		rst = 1'b1;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		pos_x = '0;
		for (i = 0; i < VRAM_WORDS; i++)
			vram[i] = lcg_next() ^ (32'(i) << 2);
		build_table();
		repeat (3) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		for (i = 0; i < ops.size(); i++)
			run_op(ops[i]);
		u_checker.report();
		if (u_checker.failures() == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* video_checker.sv */
module video_checker (
	input logic i_clock,
	input logic i_cpu_ready,
	input video_pkg::word_t i_cpu_rdata,
	input video_pkg::rgb_t i_pixel_rgb
);

	timeunit 1ns;
	timeprecision 100ps;

	int checks_done = 0;
	int value_errors = 0;
	int other_failures = 0;

	// Expected data for the CPU read in flight.
	logic read_armed = 1'b0;
	string read_name;
	video_pkg::word_t read_expected;

	// Pixel expectation, staged at each rising edge to line up with the colour register.
	logic pix_armed = 1'b0;
	string pix_name;
	video_pkg::rgb_t pix_expected;
	logic pix_armed_q = 1'b0;
	string pix_name_q;
	video_pkg::rgb_t pix_expected_q;

	task automatic check_value(input string name, input video_pkg::word_t expected,
			input video_pkg::word_t actual);
		checks_done++;
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string msg);
		other_failures++;
		$display("%s", msg);
	endtask

	task automatic expect_read(input string name, input video_pkg::word_t expected);
		read_name = name;
		read_expected = expected;
		read_armed = 1'b1;
	endtask

	task automatic expect_pixel(input string name, input video_pkg::rgb_t expected);
		pix_name = name;
		pix_expected = expected;
		pix_armed = 1'b1;
	endtask

	task automatic stop_pixel();
		pix_armed = 1'b0;
	endtask

	function automatic int failures();
		return value_errors + other_failures;
	endfunction

	task automatic report();
		$display("Checks: %0d done, %0d value errors, %0d other failures",
			checks_done, value_errors, other_failures);
	endtask

	always @(posedge i_clock) begin
		pix_armed_q <= pix_armed;
		pix_name_q <= pix_name;
		pix_expected_q <= pix_expected;
	end

	// Outputs only move on the rising edge.
	always @(negedge i_clock) begin
		if (i_cpu_ready && read_armed) begin
			read_armed = 1'b0;
			check_value(read_name, read_expected, i_cpu_rdata);
		end
		if (pix_armed_q)
			check_value(pix_name_q, {8'd0, pix_expected_q}, {8'd0, i_pixel_rgb});
	end

endmodule

/* video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// ======================================================================
// Framebuffer geometry
// ======================================================================

// Bytes in one framebuffer row, one byte per pixel.
`define VIDEO_PITCH 320

// 32-bit words fetched per row.
`define VIDEO_LINE_WORDS 80

// ======================================================================
// CPU address map
// ======================================================================

// VRAM below this bound, palette up to the next one, control above.
`define VRAM_LIMIT 32'h0080_0000
`define PALETTE_LIMIT 32'h0081_0000

// Control register offsets, in words from the start of the control region.
`define CTRL_BASE_OFFSET 32'd0
`define CTRL_STATUS_OFFSET 32'd1

`endif

/* video_controller.f */
+incdir+.
video_pkg.sv
cpu_bus_decoder.sv
line_fetcher.sv
pixel_lookup.sv
video_controller.sv
video_checker.sv
tb_video_controller.sv

/* video_controller.sv */
module video_controller (
	input logic i_clock,
	input logic i_rst,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::addr_t i_cpu_address,
	input video_pkg::word_t i_cpu_wdata,
	output video_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::addr_t o_vram_pa_address,
	output video_pkg::word_t o_vram_pa_wdata,
	input video_pkg::word_t i_vram_pa_rdata,
	input logic i_vram_pa_ready,

	output logic o_vram_pb_request,
	output video_pkg::addr_t o_vram_pb_address,
	input video_pkg::word_t i_vram_pb_rdata,
	input logic i_vram_pb_ready,

	input logic i_hblank,
	input logic i_vblank,
	input video_pkg::pos_t i_pos_x,
	output video_pkg::rgb_t o_pixel_rgb
);

	logic pal_we;
	video_pkg::pal_index_t pal_index;
	video_pkg::rgb_t pal_data;
	video_pkg::addr_t frame_base;
	logic fetch_busy;
	logic line_we;
	video_pkg::line_index_t line_index;
	video_pkg::word_t line_data;

	cpu_bus_decoder u_decoder (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_vram_pa_request(o_vram_pa_request),
		.o_vram_pa_rw(o_vram_pa_rw),
		.o_vram_pa_address(o_vram_pa_address),
		.o_vram_pa_wdata(o_vram_pa_wdata),
		.i_vram_pa_rdata(i_vram_pa_rdata),
		.i_vram_pa_ready(i_vram_pa_ready),
		.o_pal_we(pal_we),
		.o_pal_index(pal_index),
		.o_pal_data(pal_data),
		.o_frame_base(frame_base),
		.i_fetch_busy(fetch_busy)
	);

	line_fetcher u_fetcher (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_hblank(i_hblank),
		.i_vblank(i_vblank),
		.i_frame_base(frame_base),
		.o_vram_pb_request(o_vram_pb_request),
		.o_vram_pb_address(o_vram_pb_address),
		.i_vram_pb_rdata(i_vram_pb_rdata),
		.i_vram_pb_ready(i_vram_pb_ready),
		.o_line_we(line_we),
		.o_line_index(line_index),
		.o_line_data(line_data),
		.o_fetch_busy(fetch_busy)
	);

	pixel_lookup u_pixel (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_line_we(line_we),
		.i_line_index(line_index),
		.i_line_data(line_data),
		.i_pal_we(pal_we),
		.i_pal_index(pal_index),
		.i_pal_data(pal_data),
		.i_pos_x(i_pos_x),
		.o_pixel_rgb(o_pixel_rgb)
	);

endmodule

/* video_pkg.sv */
package video_pkg;

	// ==================================================================
	// Bus and memory types
	// ==================================================================

	// Byte address on the CPU bus or into VRAM.
	typedef logic [31:0] addr_t;

	// One bus or VRAM data word.
	typedef logic [31:0] word_t;

	// ==================================================================
	// Video types
	// ==================================================================

	typedef logic [7:0] pal_index_t;
	typedef logic [23:0] rgb_t;

	// Word slot in the line buffer, 80 words fit in 7 bits.
	typedef logic [6:0] line_index_t;

	// Raster coordinate from the external timing generator.
	typedef logic [9:0] pos_t;

	// Line fetcher FSM.
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_WAIT_READY,
		FETCH_GAP
	} fetch_state_t;

endpackage
